// File: pu_ctrl_top.f
+incdir+design
design/pu_ctrl_pkg.sv
design/pu_ctrl_fsm.sv
design/pu_inst_decoder.sv
design/pu_inst_buffer.sv
design/pu_alu_issue.sv
design/pu_ctrl_top.sv
sim/pu_clk_gen.sv
sim/pu_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f pu_ctrl_top.f --top-module pu_ctrl_tb -o pu_ctrl_sim
./obj_dir/pu_ctrl_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"

// File: sim/pu_ctrl_tb.sv
`timescale 1ns/1ns
`include "pu_ctrl_cfg.svh"

module pu_ctrl_tb;

  // longest block is 20 entries x 4 passes, about 3x that under back-pressure,
  // plus loading, so a few hundred cycles; the limit leaves wide margin
  localparam int MAX_CYCLES = 5000;

  logic clk, reset;
  logic pu_block_start, pu_compute_start, pu_compute_ready, done;
  logic inst_wr_req, inst_wr_ready;
  pu_ctrl_pkg::inst_t inst_wr_data;
  logic cfg_loop_iter_v, cfg_loop_stride_v, cfg_mem_req_v;
  pu_ctrl_pkg::imm_t cfg_loop_iter;
  logic [2:0] cfg_loop_iter_type;
  pu_ctrl_pkg::stride_t cfg_loop_stride;
  logic [3:0] cfg_loop_stride_type;
  logic [1:0] cfg_mem_req_type;
  logic [2:0] upsample_num;
  logic alu_fn_valid, alu_in1_src;
  pu_ctrl_pkg::alu_fn_t alu_fn;
  pu_ctrl_pkg::rf_addr_t alu_in0_addr, alu_out_addr;
  pu_ctrl_pkg::imm_t alu_imm;
  logic obuf_ld_stream_read_req, obuf_ld_stream_read_ready;
  logic ddr_st_stream_write_req, ddr_st_stream_write_ready;

  int errors = 0;
  int cycle_cnt = 0;
  logic [31:0] rnd;
  pu_ctrl_pkg::inst_t model[$];               // stored compute list, in order

  pu_clk_gen i_clk_gen (.clk(clk), .reset(reset));

  pu_ctrl_top i_pu_ctrl_top (.*);

  task automatic report_error(input string msg);
    errors++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  // word is {op_code, op_spec, loop_id, imm}
  function automatic pu_ctrl_pkg::inst_t make_word(input logic [`OP_CODE_W-1:0] op,
      input logic [`OP_SPEC_W-1:0] spec, input logic [`LOOP_ID_W-1:0] lid,
      input logic [`IMM_W-1:0] imm);
    return {op, spec, lid, imm};
  endfunction

  task automatic start_block();
    @(negedge clk);
    pu_block_start = 1'b1;
    @(negedge clk);
    pu_block_start = 1'b0;
  endtask

  task automatic send_inst(input pu_ctrl_pkg::inst_t word);
    @(negedge clk);
    inst_wr_req  = 1'b1;
    inst_wr_data = word;
    #1;                                       // decode outputs settle
  endtask

  task automatic check_strobes(input logic [2:0] exp, input string what);
    if ({cfg_loop_iter_v, cfg_loop_stride_v, cfg_mem_req_v} !== exp)
      report_error({what, ": wrong configuration strobes"});
  endtask

  // ========================================
  // load, replay and per-cycle checks
  // ========================================
  task automatic replay_block(input int n, input int r, input bit pressure);
    pu_ctrl_pkg::inst_t word;
    logic obuf_need, st_need, exp_valid, exp_store;
    logic [`ST_REQ_DELAY-1:0] st_hist;
    int total, issued, tail;
    model.delete();
    for (int i = 0; i < n; i++) begin
      rnd  = $urandom;
      word = {rnd[31] ? `OP_CODE_W'(`OP_COMPUTE_I) : `OP_CODE_W'(`OP_COMPUTE_R), rnd[27:0]};
      model.push_back(word);
      send_inst(word);
      check_strobes(3'b000, "compute entry");
    end
    send_inst(make_word(`OP_BLOCK_REPEAT, 7'h00, 5'd0, 16'(r)));
    @(negedge clk);
    inst_wr_req      = 1'b0;
    pu_compute_start = 1'b1;
    #1;
    if (pu_compute_ready !== 1'b1) report_error("pu_compute_ready low after BLOCK_REPEAT");
    total   = n * (r + 1);
    issued  = 0;
    tail    = 0;
    st_hist = '0;
    while (tail <= `ST_REQ_DELAY) begin
      @(negedge clk);
      pu_compute_start = 1'b0;
      if (pressure) begin
        rnd = $urandom;
        obuf_ld_stream_read_ready = rnd[0];
        ddr_st_stream_write_ready = rnd[1];
      end
      #1;
      exp_store = 1'b0;
      if (issued < total) begin
        word      = model[issued % n];
        obuf_need = (word[26:24] == `FN_OBUF_A) || (word[26:24] == `FN_OBUF_B);
        st_need   = word[3];                  // top bit of out_addr
        exp_valid = !((obuf_need && !obuf_ld_stream_read_ready) ||
                      (st_need && !ddr_st_stream_write_ready));
        if (alu_fn_valid !== exp_valid) report_error("alu_fn_valid against stream readies");
        if (alu_in1_src !== word[27] || alu_fn !== word[26:24] || alu_imm !== word[23:8] ||
            alu_in0_addr !== word[7:4] || alu_out_addr !== word[3:0])
          report_error($sformatf("fields of entry %0d out of order", issued % n));
        if (obuf_ld_stream_read_req !== (obuf_need && exp_valid))
          report_error("obuf_ld_stream_read_req wrong");
        if (inst_wr_ready !== 1'b0 || done !== 1'b0)
          report_error("inst_wr_ready or done high during replay");
        if (exp_valid) begin
          exp_store = st_need;
          issued++;
        end
      end else begin
        if (done !== (tail == 0)) report_error("done not one pulse after the last issue");
        if (alu_fn_valid !== 1'b0) report_error("issue after the last pass");
        tail++;
      end
      if (ddr_st_stream_write_req !== st_hist[`ST_REQ_DELAY-1])
        report_error("ddr_st_stream_write_req not two cycles after a store issue");
      st_hist = {st_hist[`ST_REQ_DELAY-2:0], exp_store};
    end
    obuf_ld_stream_read_ready = 1'b1;
    ddr_st_stream_write_ready = 1'b1;
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic test_reset_state();
    @(posedge clk);                           // reset applied by now
    while (reset) @(negedge clk);
    #1;
    if (done !== 1'b0 || pu_compute_ready !== 1'b0 || alu_fn_valid !== 1'b0)
      report_error("status outputs not low after reset");
    check_strobes(3'b000, "reset");
    if (obuf_ld_stream_read_req !== 1'b0 || ddr_st_stream_write_req !== 1'b0)
      report_error("stream requests not low after reset");
    if (inst_wr_ready !== 1'b1) report_error("inst_wr_ready low after reset");
  endtask

  task automatic test_config_decode();
    logic [`OP_SPEC_W-1:0] spec;
    start_block();
    spec = 7'h2d;
    send_inst(make_word(`OP_LOOP, spec, 5'd3, 16'h1234));
    check_strobes(3'b100, "LOOP");
    if (cfg_loop_iter !== 16'h1234 || cfg_loop_iter_type !== spec[2:0])
      report_error("LOOP fields");
    spec = 7'h1a;
    send_inst(make_word(`OP_LDMEM, spec, 5'd0, 16'h0000));
    check_strobes(3'b001, "LDMEM");
    if (cfg_mem_req_type !== spec[4:3] || upsample_num !== spec[2:0])
      report_error("LDMEM fields");
    send_inst(make_word(`OP_GENADDR_HI, 7'h00, 5'd1, 16'hbeef));
    check_strobes(3'b000, "GENADDR_HI");
    spec = 7'h4a;
    send_inst(make_word(`OP_GENADDR_LO, spec, 5'd1, 16'h5678));
    check_strobes(3'b010, "GENADDR_LO");
    if (cfg_loop_stride !== 32'hbeef_5678 || cfg_loop_stride_type !== spec[3:0])
      report_error("GENADDR_LO fields");
    send_inst(make_word(`OP_GENADDR_LO, spec, 5'd2, 16'h9abc));
    check_strobes(3'b010, "second GENADDR_LO");
    if (cfg_loop_stride !== 32'h0000_9abc) report_error("stride high half not cleared");
    replay_block(2, 0, 1'b0);                 // closes the block
  endtask

  task automatic test_replay(input int n, input int r, input bit pressure);
    start_block();
    replay_block(n, r, pressure);
  endtask

  initial begin
    pu_block_start            = 1'b0;
    pu_compute_start          = 1'b0;
    inst_wr_req               = 1'b0;
    inst_wr_data              = '0;
    obuf_ld_stream_read_ready = 1'b1;
    ddr_st_stream_write_ready = 1'b1;
    rnd = $urandom(32'hf1ca_7707);
    test_reset_state();
    test_config_decode();
    test_replay(12, 2, 1'b0);
    test_replay(20, 3, 1'b1);                 // random back-pressure
    test_replay(5, 1, 1'b0);                  // shorter block after a longer one
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// File: sim/pu_clk_gen.sv
`timescale 1ns/1ns

module pu_clk_gen #(
  parameter int HALF_PERIOD  = 2,             // 4 ns clock
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;                             // released between edges
  end

endmodule

// File: design/pu_ctrl_top.sv
`timescale 1ns/1ns

module pu_ctrl_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pu_block_start,
  input  logic                  pu_compute_start,
  output logic                  pu_compute_ready,
  output logic                  done,
  input  logic                  inst_wr_req,
  input  pu_ctrl_pkg::inst_t    inst_wr_data,
  output logic                  inst_wr_ready,
  output logic                  cfg_loop_iter_v,
  output pu_ctrl_pkg::imm_t     cfg_loop_iter,
  output logic [2:0]            cfg_loop_iter_type,
  output logic                  cfg_loop_stride_v,
  output pu_ctrl_pkg::stride_t  cfg_loop_stride,
  output logic [3:0]            cfg_loop_stride_type,
  output logic                  cfg_mem_req_v,
  output logic [1:0]            cfg_mem_req_type,
  output logic [2:0]            upsample_num,
  output logic                  alu_fn_valid,
  output pu_ctrl_pkg::alu_fn_t  alu_fn,
  output pu_ctrl_pkg::rf_addr_t alu_in0_addr,
  output pu_ctrl_pkg::rf_addr_t alu_out_addr,
  output logic                  alu_in1_src,
  output pu_ctrl_pkg::imm_t     alu_imm,
  output logic                  obuf_ld_stream_read_req,
  input  logic                  obuf_ld_stream_read_ready,
  output logic                  ddr_st_stream_write_req,
  input  logic                  ddr_st_stream_write_ready
);

  logic               decode_active;
  logic               compute_active;
  logic               inst_store;
  logic               block_end;
  pu_ctrl_pkg::imm_t  block_repeat;
  pu_ctrl_pkg::inst_t issue_inst;
  logic               issue_last;

  pu_ctrl_fsm i_fsm (
    .clk              (clk),
    .reset            (reset),
    .pu_block_start   (pu_block_start),
    .pu_compute_start (pu_compute_start),
    .block_end        (block_end),
    .block_repeat     (block_repeat),
    .alu_fn_valid     (alu_fn_valid),
    .issue_last       (issue_last),
    .decode_active    (decode_active),
    .compute_active   (compute_active),
    .done             (done),
    .pu_compute_ready (pu_compute_ready),
    .inst_wr_ready    (inst_wr_ready)
  );

  pu_inst_decoder i_decoder (
    .clk                  (clk),
    .reset                (reset),
    .decode_active        (decode_active),
    .done                 (done),
    .inst_wr_req          (inst_wr_req),
    .inst_wr_data         (inst_wr_data),
    .cfg_loop_iter_v      (cfg_loop_iter_v),
    .cfg_loop_iter        (cfg_loop_iter),
    .cfg_loop_iter_type   (cfg_loop_iter_type),
    .cfg_loop_stride_v    (cfg_loop_stride_v),
    .cfg_loop_stride      (cfg_loop_stride),
    .cfg_loop_stride_type (cfg_loop_stride_type),
    .cfg_mem_req_v        (cfg_mem_req_v),
    .cfg_mem_req_type     (cfg_mem_req_type),
    .upsample_num         (upsample_num),
    .inst_store           (inst_store),
    .block_end            (block_end),
    .block_repeat         (block_repeat)
  );

  pu_inst_buffer i_buffer (
    .clk          (clk),
    .reset        (reset),
    .done         (done),
    .inst_store   (inst_store),
    .inst_wr_data (inst_wr_data),
    .alu_fn_valid (alu_fn_valid),
    .issue_inst   (issue_inst),
    .issue_last   (issue_last)
  );

  pu_alu_issue i_alu_issue (
    .clk                       (clk),
    .reset                     (reset),
    .compute_active            (compute_active),
    .issue_inst                (issue_inst),
    .obuf_ld_stream_read_ready (obuf_ld_stream_read_ready),
    .ddr_st_stream_write_ready (ddr_st_stream_write_ready),
    .alu_fn_valid              (alu_fn_valid),
    .alu_fn                    (alu_fn),
    .alu_in0_addr              (alu_in0_addr),
    .alu_out_addr              (alu_out_addr),
    .alu_in1_src               (alu_in1_src),
    .alu_imm                   (alu_imm),
    .obuf_ld_stream_read_req   (obuf_ld_stream_read_req),
    .ddr_st_stream_write_req   (ddr_st_stream_write_req)
  );

endmodule

// File: design/pu_alu_issue.sv
`timescale 1ns/1ns
`include "pu_ctrl_cfg.svh"

module pu_alu_issue (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  compute_active,
  input  pu_ctrl_pkg::inst_t    issue_inst,
  input  logic                  obuf_ld_stream_read_ready,
  input  logic                  ddr_st_stream_write_ready,
  output logic                  alu_fn_valid,
  output pu_ctrl_pkg::alu_fn_t  alu_fn,
  output pu_ctrl_pkg::rf_addr_t alu_in0_addr,
  output pu_ctrl_pkg::rf_addr_t alu_out_addr,
  output logic                  alu_in1_src,
  output pu_ctrl_pkg::imm_t     alu_imm,
  output logic                  obuf_ld_stream_read_req,
  output logic                  ddr_st_stream_write_req
);

  logic                     obuf_need;
  logic                     st_need;
  logic                     stall;
  logic [`ST_REQ_DELAY-1:0] st_req_pipe;        // store issue history

  // ========================================
  // field split and stall
  // ========================================
  assign {alu_in1_src, alu_fn, alu_imm, alu_in0_addr, alu_out_addr} =
    issue_inst[`ALU_FIELD_W-1:0];

  assign obuf_need = (alu_fn == `FN_OBUF_A) || (alu_fn == `FN_OBUF_B);
  assign st_need   = alu_out_addr[`RF_ADDR_W-1];  // top bit selects ddr store

  assign stall = compute_active &&
                 ((obuf_need && !obuf_ld_stream_read_ready) ||
                  (st_need && !ddr_st_stream_write_ready));

  assign alu_fn_valid            = compute_active && !stall;
  assign obuf_ld_stream_read_req = obuf_need && alu_fn_valid;

  // store data reaches the ddr stream after the alu pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      st_req_pipe <= '0;
    end else begin
      st_req_pipe <= {st_req_pipe[`ST_REQ_DELAY-2:0], st_need && alu_fn_valid};
    end
  end

  assign ddr_st_stream_write_req = st_req_pipe[`ST_REQ_DELAY-1];

endmodule

// File: design/pu_inst_buffer.sv
`timescale 1ns/1ns
`include "pu_ctrl_cfg.svh"

module pu_inst_buffer (
  input  logic               clk,
  input  logic               reset,
  input  logic               done,
  input  logic               inst_store,
  input  pu_ctrl_pkg::inst_t inst_wr_data,
  input  logic               alu_fn_valid,
  output pu_ctrl_pkg::inst_t issue_inst,
  output logic               issue_last
);

  localparam int DEPTH = 1 << `IMEM_ADDR_W;

  pu_ctrl_pkg::inst_t      mem [DEPTH];
  pu_ctrl_pkg::imem_addr_t wr_ptr;
  pu_ctrl_pkg::imem_addr_t last_idx;           // index of newest entry
  pu_ctrl_pkg::imem_addr_t rd_ptr;             // entry on issue_inst
  pu_ctrl_pkg::imem_addr_t rd_addr;

  // ========================================
  // write side
  // ========================================
  always_ff @(posedge clk) begin
    if (reset || done) begin
      wr_ptr   <= '0;
      last_idx <= '0;
    end else if (inst_store) begin
      wr_ptr   <= wr_ptr + 1'b1;
      last_idx <= wr_ptr;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_store) begin
      mem[wr_ptr] <= inst_wr_data;
    end
  end

  // ========================================
  // read side
  // ========================================
  // prefetch the successor on issue so replay has no bubbles
  always_comb begin
    rd_addr = rd_ptr;
    if (alu_fn_valid) begin
      rd_addr = (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;  // wrap per pass
    end
  end

  always_ff @(posedge clk) begin
    if (reset || done) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    issue_inst <= mem[rd_addr];             // registered read port
  end

  assign issue_last = (rd_ptr == last_idx);

  // all 64 entries written means pointer wrapped onto entry 0
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    inst_store |-> !(wr_ptr == '0 && last_idx == '1));

endmodule

// File: design/pu_inst_decoder.sv
`timescale 1ns/1ns
`include "pu_ctrl_cfg.svh"

module pu_inst_decoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 decode_active,
  input  logic                 done,
  input  logic                 inst_wr_req,
  input  pu_ctrl_pkg::inst_t   inst_wr_data,
  output logic                 cfg_loop_iter_v,
  output pu_ctrl_pkg::imm_t    cfg_loop_iter,
  output logic [2:0]           cfg_loop_iter_type,
  output logic                 cfg_loop_stride_v,
  output pu_ctrl_pkg::stride_t cfg_loop_stride,
  output logic [3:0]           cfg_loop_stride_type,
  output logic                 cfg_mem_req_v,
  output logic [1:0]           cfg_mem_req_type,
  output logic [2:0]           upsample_num,
  output logic                 inst_store,
  output logic                 block_end,
  output pu_ctrl_pkg::imm_t    block_repeat
);

  logic [`OP_CODE_W-1:0] op_code;
  pu_ctrl_pkg::op_spec_t op_spec;
  pu_ctrl_pkg::imm_t     imm;
  logic                  inst_valid;
  pu_ctrl_pkg::imm_t     stride_hi;             // upper half from GENADDR_HI

  assign op_code    = inst_wr_data[`OP_CODE_LSB +: `OP_CODE_W];
  assign op_spec    = inst_wr_data[`OP_SPEC_LSB +: `OP_SPEC_W];
  assign imm        = inst_wr_data[`IMM_W-1:0];
  assign inst_valid = decode_active && inst_wr_req;

  // ========================================
  // configuration strobes
  // ========================================
  assign cfg_loop_iter_v      = inst_valid && (op_code == `OP_LOOP);
  assign cfg_loop_iter        = imm;
  assign cfg_loop_iter_type   = op_spec[2:0];

  assign cfg_loop_stride_v    = inst_valid && (op_code == `OP_GENADDR_LO);
  assign cfg_loop_stride      = {stride_hi, imm};
  assign cfg_loop_stride_type = op_spec[3:0];

  assign cfg_mem_req_v        = inst_valid && (op_code == `OP_LDMEM);
  assign cfg_mem_req_type     = op_spec[4:3];
  assign upsample_num         = op_spec[2:0];

  assign inst_store   = inst_valid &&
                        (op_code == `OP_COMPUTE_R || op_code == `OP_COMPUTE_I);
  assign block_end    = inst_valid && (op_code == `OP_BLOCK_REPEAT);
  assign block_repeat = imm;                    // extra passes over the list

  // consumed by the next GENADDR_LO, dropped at block end
  always_ff @(posedge clk) begin
    if (reset || cfg_loop_stride_v || done) begin
      stride_hi <= '0;
    end else if (inst_valid && op_code == `OP_GENADDR_HI) begin
      stride_hi <= imm;
    end
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (reset)
    $onehot0({cfg_loop_iter_v, cfg_loop_stride_v, cfg_mem_req_v, inst_store, block_end}));

endmodule

// File: design/pu_ctrl_fsm.sv
`timescale 1ns/1ns

module pu_ctrl_fsm (
  input  logic              clk,
  input  logic              reset,
  input  logic              pu_block_start,
  input  logic              pu_compute_start,
  input  logic              block_end,
  input  pu_ctrl_pkg::imm_t block_repeat,
  input  logic              alu_fn_valid,
  input  logic              issue_last,
  output logic              decode_active,
  output logic              compute_active,
  output logic              done,
  output logic              pu_compute_ready,
  output logic              inst_wr_ready
);

  pu_ctrl_pkg::pu_state_t state;
  pu_ctrl_pkg::pu_state_t state_next;
  pu_ctrl_pkg::imm_t      repeat_cnt;          // passes left after this one
  pu_ctrl_pkg::imm_t      repeat_cnt_next;

  // ========================================
  // next state
  // ========================================
  always_comb begin
    state_next      = state;
    repeat_cnt_next = repeat_cnt;
    case (state)
      pu_ctrl_pkg::IDLE: begin
        if (pu_block_start) begin
          state_next = pu_ctrl_pkg::DECODE;
        end
      end
      pu_ctrl_pkg::DECODE: begin
        if (block_end) begin
          state_next      = pu_ctrl_pkg::COMPUTE_WAIT;
          repeat_cnt_next = block_repeat;
        end
      end
      pu_ctrl_pkg::COMPUTE_WAIT: begin
        if (pu_compute_start) begin
          state_next = pu_ctrl_pkg::COMPUTE;
        end
      end
      pu_ctrl_pkg::COMPUTE: begin
        if (alu_fn_valid && issue_last) begin      // end of one pass
          if (repeat_cnt == '0) begin
            state_next = pu_ctrl_pkg::DONE;
          end else begin
            repeat_cnt_next = repeat_cnt - 1'b1;
          end
        end
      end
      default: state_next = pu_ctrl_pkg::IDLE;     // DONE lasts one cycle
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= pu_ctrl_pkg::IDLE;
      repeat_cnt <= '0;
    end else begin
      state      <= state_next;
      repeat_cnt <= repeat_cnt_next;
    end
  end

  assign decode_active    = (state == pu_ctrl_pkg::DECODE);
  assign compute_active   = (state == pu_ctrl_pkg::COMPUTE);
  assign done             = (state == pu_ctrl_pkg::DONE);
  assign pu_compute_ready = (state == pu_ctrl_pkg::COMPUTE_WAIT);
  assign inst_wr_ready    = (state != pu_ctrl_pkg::COMPUTE);  // busy only in replay

  a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done);

  // the issue stage must never fire outside replay
  a_issue_in_compute: assert property (@(posedge clk) disable iff (reset)
    alu_fn_valid |-> state == pu_ctrl_pkg::COMPUTE);

endmodule

// File: design/pu_ctrl_pkg.sv
`include "pu_ctrl_cfg.svh"

package pu_ctrl_pkg;

  // ========================================
  // datapath vectors
  // ========================================
  typedef logic [`INST_W-1:0]      inst_t;
  typedef logic [`IMM_W-1:0]       imm_t;       // imm, loop count, repeat count
  typedef logic [`STRIDE_W-1:0]    stride_t;
  typedef logic [`OP_SPEC_W-1:0]   op_spec_t;
  typedef logic [`FN_W-1:0]        alu_fn_t;
  typedef logic [`RF_ADDR_W-1:0]   rf_addr_t;
  typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;

  // ========================================
  // controller states
  // ========================================
  typedef enum logic [2:0] {
    IDLE,                               // waiting for a block
    DECODE,                             // loading instructions
    COMPUTE_WAIT,                       // block loaded
    COMPUTE,                            // replaying to the alu
    DONE                                // one-cycle completion
  } pu_state_t;

endpackage

// File: design/pu_ctrl_cfg.svh
`ifndef PU_CTRL_CFG_SVH
`define PU_CTRL_CFG_SVH

// ========================================
// widths
// ========================================
`define INST_W        32
`define IMM_W         16
`define STRIDE_W      32                // {hi, lo} halves of imm
`define OP_CODE_W     4
`define OP_SPEC_W     7
`define LOOP_ID_W     5
`define IMEM_ADDR_W   6                 // 64 buffer entries
`define FN_W          3
`define RF_ADDR_W     4

// field positions, word is {op_code, op_spec, loop_id, imm}
`define OP_SPEC_LSB   (`IMM_W + `LOOP_ID_W)
`define OP_CODE_LSB   (`OP_SPEC_LSB + `OP_SPEC_W)
`define ALU_FIELD_W   (1 + `FN_W + `IMM_W + 2 * `RF_ADDR_W)

`define ST_REQ_DELAY  2                 // issue to ddr store request

// ========================================
// opcodes
// ========================================
`define OP_LDMEM        1
`define OP_GENADDR_HI   5
`define OP_GENADDR_LO   6
`define OP_LOOP         7
`define OP_BLOCK_REPEAT 8
`define OP_COMPUTE_R    11
`define OP_COMPUTE_I    12

// alu functions reading the output buffer
`define FN_OBUF_A       3
`define FN_OBUF_B       4

`endif
